/* Makefile */
# Verilator build, lint and run of the cluster peripheral subsystem

LOG := sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f cluster_periph_top.f --top-module cluster_periph_tb -o Vcluster_periph_tb
	./obj_dir/Vcluster_periph_tb | tee $(LOG)
	grep -q "Verification passed" $(LOG)

lint:
	verilator --lint-only --timing --timescale 1ns/100ps \
		-f cluster_periph_top.f --top-module cluster_periph_top

clean:
	rm -rf obj_dir $(LOG)

/* cluster_periph_top.f */
+incdir+source
source/periph_bus_pkg.sv
source/cluster_ctrl_pkg.sv
source/cluster_control_unit.sv
source/cluster_timer.sv
source/event_unit.sv
source/cluster_peripherals.sv
source/periph_bus_arbiter.sv
source/cluster_periph_top.sv
verif/cluster_periph_tb.sv

/* source/cluster_control_unit.sv */
// Fetch enable, boot address and end-of-computation registers
// Offsets 0x0, 0x4 and 0x8, all of them read back
// Other offsets read 0
`timescale 1ns/100ps
`default_nettype none

`include "cluster_defs.svh"

module cluster_control_unit (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         sel_i,
  input  logic                         we_i,
  input  logic [7:0]                   offset_i,
  input  periph_bus_pkg::periph_data_t wdata_i,
  output periph_bus_pkg::periph_data_t rdata_o,
  output cluster_ctrl_pkg::core_mask_t fetch_enable_o,
  output periph_bus_pkg::periph_data_t boot_addr_o,
  output logic                         eoc_o
);
  import periph_bus_pkg::*;
  import cluster_ctrl_pkg::*;

  ctrl_wdata_u  wdata_u;
  core_mask_t   fetch_en_q;
  periph_data_t boot_addr_q;
  logic         eoc_q;
  logic         wr_en;

  assign wdata_u = wdata_i;
  assign wr_en   = sel_i && we_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fetch_en_q  <= '0;
      boot_addr_q <= `BOOT_ADDR_RST;
      eoc_q       <= 1'b0;
    end else if (wr_en) begin
      case (offset_i)
        8'h00: fetch_en_q  <= wdata_u.core.mask;
        8'h04: boot_addr_q <= wdata_u.boot_addr;
        8'h08: eoc_q       <= wdata_i[0];
        default: ;
      endcase
    end
  end

  always_comb begin
    case (offset_i)
      8'h00:   rdata_o = periph_data_t'(fetch_en_q);
      8'h04:   rdata_o = boot_addr_q;
      8'h08:   rdata_o = periph_data_t'(eoc_q);
      default: rdata_o = '0;
    endcase
  end

  assign fetch_enable_o = fetch_en_q;
  assign boot_addr_o    = boot_addr_q;
  assign eoc_o          = eoc_q;

endmodule

`default_nettype wire

/* source/cluster_ctrl_pkg.sv */
// Types for control unit and event unit registers
// The core mask sits in the low bits of a 32-bit bus word
`default_nettype none

`include "cluster_defs.svh"

package cluster_ctrl_pkg;

  // One bit per core
  typedef logic [`NB_CORES-1:0] core_mask_t;

  // Control unit write word, read as a mask or as a full boot address
  typedef union packed {
    struct packed {
      logic [31-`NB_CORES:0] rsvd;
      core_mask_t            mask;
    } core;
    logic [31:0] boot_addr;
  } ctrl_wdata_u;

  // Bit 0 is the timer event, bits 7:1 come from outside the cluster
  typedef logic [7:0] evt_vec_t;

endpackage

`default_nettype wire

/* source/cluster_defs.svh */
// Build-time configuration of the cluster peripheral subsystem
// Address bits 11:8 pick the peripheral and bits 7:0 are the register offset
// The arbiter is written for a power-of-two master count
`ifndef CLUSTER_DEFS_SVH
`define CLUSTER_DEFS_SVH

// Cores receiving fetch enables and interrupt lines
`define NB_CORES 4
// Four-phase req/ack master ports
`define NB_MASTERS 2
`define PERIPH_ADDR_W 12

// Peripheral map, value of address bits 11:8
`define PER_CTRL_BASE 4'h0
`define PER_TIMER_BASE 4'h1
`define PER_EU_BASE 4'h2

`define BOOT_ADDR_RST 32'h1C00_0000

`endif

/* source/cluster_periph_top.sv */
// Cluster peripheral subsystem, arbiter in front of the peripherals
// Masters follow the four-phase req/ack rule described in the arbiter
`timescale 1ns/100ps
`default_nettype none

`include "cluster_defs.svh"

module cluster_periph_top (
  input  logic                                           clk_i,
  input  logic                                           reset_i,
  input  logic [`NB_MASTERS-1:0]                         req_i,
  input  logic [`NB_MASTERS-1:0]                         we_i,
  input  periph_bus_pkg::periph_addr_t [`NB_MASTERS-1:0] addr_i,
  input  periph_bus_pkg::periph_data_t [`NB_MASTERS-1:0] wdata_i,
  output logic [`NB_MASTERS-1:0]                         ack_o,
  output periph_bus_pkg::periph_data_t [`NB_MASTERS-1:0] rdata_o,
  input  logic [6:0]                                     evt_i,
  output cluster_ctrl_pkg::core_mask_t                   fetch_enable_o,
  output periph_bus_pkg::periph_data_t                   boot_addr_o,
  output logic                                           eoc_o,
  output cluster_ctrl_pkg::core_mask_t                   irq_o
);
  import periph_bus_pkg::*;

  // Shared single-cycle bus
  logic         bus_req;
  logic         bus_we;
  periph_addr_t bus_addr;
  periph_data_t bus_wdata;
  periph_data_t bus_rdata;

  periph_bus_arbiter u_arb (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_i       (req_i),
    .we_i        (we_i),
    .addr_i      (addr_i),
    .wdata_i     (wdata_i),
    .ack_o       (ack_o),
    .rdata_o     (rdata_o),
    .bus_req_o   (bus_req),
    .bus_we_o    (bus_we),
    .bus_addr_o  (bus_addr),
    .bus_wdata_o (bus_wdata),
    .bus_rdata_i (bus_rdata)
  );

  cluster_peripherals u_periph (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .bus_req_i      (bus_req),
    .bus_we_i       (bus_we),
    .bus_addr_i     (bus_addr),
    .bus_wdata_i    (bus_wdata),
    .bus_rdata_o    (bus_rdata),
    .evt_i          (evt_i),
    .fetch_enable_o (fetch_enable_o),
    .boot_addr_o    (boot_addr_o),
    .eoc_o          (eoc_o),
    .irq_o          (irq_o)
  );

endmodule

`default_nettype wire

/* source/cluster_peripherals.sv */
// Address decode and read mux for the three cluster peripherals
// Every peripheral answers in the cycle of the access
// Unmapped addresses read 0 and ignore writes
`timescale 1ns/100ps
`default_nettype none

`include "cluster_defs.svh"

module cluster_peripherals (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         bus_req_i,
  input  logic                         bus_we_i,
  input  periph_bus_pkg::periph_addr_t bus_addr_i,
  input  periph_bus_pkg::periph_data_t bus_wdata_i,
  output periph_bus_pkg::periph_data_t bus_rdata_o,
  input  logic [6:0]                   evt_i,
  output cluster_ctrl_pkg::core_mask_t fetch_enable_o,
  output periph_bus_pkg::periph_data_t boot_addr_o,
  output logic                         eoc_o,
  output cluster_ctrl_pkg::core_mask_t irq_o
);
  import periph_bus_pkg::*;
  import cluster_ctrl_pkg::*;

  periph_sel_e  sel;
  logic [7:0]   offset;
  logic         ctrl_sel;
  logic         timer_sel;
  logic         eu_sel;
  periph_data_t ctrl_rdata;
  periph_data_t timer_rdata;
  periph_data_t eu_rdata;
  logic         timer_evt;
  evt_vec_t     evt_vec;

  always_comb begin
    case (bus_addr_i[`PERIPH_ADDR_W-1 -: 4])
      `PER_CTRL_BASE:  sel = CTRL;
      `PER_TIMER_BASE: sel = TIMER;
      `PER_EU_BASE:    sel = EU;
      default:         sel = NONE;
    endcase
  end

  assign offset    = bus_addr_i[7:0];
  assign ctrl_sel  = bus_req_i && (sel == CTRL);
  assign timer_sel = bus_req_i && (sel == TIMER);
  assign eu_sel    = bus_req_i && (sel == EU);

  always_comb begin
    case (sel)
      CTRL:    bus_rdata_o = ctrl_rdata;
      TIMER:   bus_rdata_o = timer_rdata;
      EU:      bus_rdata_o = eu_rdata;
      default: bus_rdata_o = '0;
    endcase
  end

  // Timer event in bit 0, external events above it
  assign evt_vec = {evt_i, timer_evt};

  //**************************************************
  // Control unit
  //**************************************************
  cluster_control_unit u_ctrl (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .sel_i          (ctrl_sel),
    .we_i           (bus_we_i),
    .offset_i       (offset),
    .wdata_i        (bus_wdata_i),
    .rdata_o        (ctrl_rdata),
    .fetch_enable_o (fetch_enable_o),
    .boot_addr_o    (boot_addr_o),
    .eoc_o          (eoc_o)
  );

  //**************************************************
  // Timer
  //**************************************************
  cluster_timer u_timer (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .sel_i       (timer_sel),
    .we_i        (bus_we_i),
    .offset_i    (offset),
    .wdata_i     (bus_wdata_i),
    .rdata_o     (timer_rdata),
    .timer_evt_o (timer_evt)
  );

  //**************************************************
  // Event unit
  //**************************************************
  event_unit u_eu (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .sel_i    (eu_sel),
    .we_i     (bus_we_i),
    .offset_i (offset),
    .wdata_i  (bus_wdata_i),
    .rdata_o  (eu_rdata),
    .evt_i    (evt_vec),
    .irq_o    (irq_o)
  );

endmodule

`default_nettype wire

/* source/cluster_timer.sv */
// 32-bit cluster timer counting clk_i cycles
// On a compare match the count wraps to 0 and the event pulses next cycle
// A compare value of 0 with the timer enabled fires every cycle
`timescale 1ns/100ps
`default_nettype none

module cluster_timer (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         sel_i,
  input  logic                         we_i,
  input  logic [7:0]                   offset_i,
  input  periph_bus_pkg::periph_data_t wdata_i,
  output periph_bus_pkg::periph_data_t rdata_o,
  output logic                         timer_evt_o
);
  import periph_bus_pkg::*;

  logic         enable_q;
  periph_data_t count_q;
  periph_data_t cmp_q;
  logic         evt_q;
  logic         match;
  logic         wr_en;

  assign wr_en = sel_i && we_i;
  assign match = enable_q && (count_q == cmp_q);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      enable_q <= 1'b0;
      count_q  <= '0;
      cmp_q    <= '0;
      evt_q    <= 1'b0;
    end else begin
      evt_q <= match;
      // Software write to the count wins over counting
      if (wr_en && offset_i == 8'h04) begin
        count_q <= wdata_i;
      end else if (match) begin
        count_q <= '0;
      end else if (enable_q) begin
        count_q <= count_q + 32'd1;
      end
      if (wr_en && offset_i == 8'h00) begin
        enable_q <= wdata_i[0];
      end
      if (wr_en && offset_i == 8'h08) begin
        cmp_q <= wdata_i;
      end
    end
  end

  always_comb begin
    case (offset_i)
      8'h00:   rdata_o = periph_data_t'(enable_q);
      8'h04:   rdata_o = count_q;
      8'h08:   rdata_o = cmp_q;
      default: rdata_o = '0;
    endcase
  end

  assign timer_evt_o = evt_q;

endmodule

`default_nettype wire

/* source/event_unit.sv */
// Pending event latch with one 8-bit mask per core
// Pending at 0x00 is write-1-to-clear, core masks at 0x10 + 4 * core
// An event in the cycle of its clear stays pending
`timescale 1ns/100ps
`default_nettype none

`include "cluster_defs.svh"

module event_unit (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         sel_i,
  input  logic                         we_i,
  input  logic [7:0]                   offset_i,
  input  periph_bus_pkg::periph_data_t wdata_i,
  output periph_bus_pkg::periph_data_t rdata_o,
  input  cluster_ctrl_pkg::evt_vec_t   evt_i,
  output cluster_ctrl_pkg::core_mask_t irq_o
);
  import periph_bus_pkg::*;
  import cluster_ctrl_pkg::*;

  evt_vec_t                 pending_q;
  evt_vec_t [`NB_CORES-1:0] mask_q;
  core_mask_t               irq_q;
  evt_vec_t                 clr;
  logic                     wr_en;

  assign wr_en = sel_i && we_i;
  assign clr   = (wr_en && offset_i == 8'h00) ? wdata_i[7:0] : '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_q <= '0;
      mask_q    <= '0;
      irq_q     <= '0;
    end else begin
      pending_q <= (pending_q & ~clr) | evt_i;
      for (int c = 0; c < `NB_CORES; c++) begin
        if (wr_en && offset_i == 8'(8'h10 + 4 * c)) begin
          mask_q[c] <= wdata_i[7:0];
        end
        // One register stage from pending and mask to the line
        irq_q[c] <= |(pending_q & mask_q[c]);
      end
    end
  end

  //**************************************************
  // Register read
  //**************************************************
  always_comb begin
    rdata_o = '0;
    if (offset_i == 8'h00) begin
      rdata_o = periph_data_t'(pending_q);
    end
    for (int c = 0; c < `NB_CORES; c++) begin
      if (offset_i == 8'(8'h10 + 4 * c)) begin
        rdata_o = periph_data_t'(mask_q[c]);
      end
    end
  end

  assign irq_o = irq_q;

endmodule

`default_nettype wire

/* source/periph_bus_arbiter.sv */
// Round-robin arbiter from four-phase req/ack masters onto the single-cycle bus
// Master fields must stay stable while req is high
// The granted master holds the bus until it drops req after ack
`timescale 1ns/100ps
`default_nettype none

`include "cluster_defs.svh"

module periph_bus_arbiter (
  input  logic                                           clk_i,
  input  logic                                           reset_i,
  input  logic [`NB_MASTERS-1:0]                         req_i,
  input  logic [`NB_MASTERS-1:0]                         we_i,
  input  periph_bus_pkg::periph_addr_t [`NB_MASTERS-1:0] addr_i,
  input  periph_bus_pkg::periph_data_t [`NB_MASTERS-1:0] wdata_i,
  output logic [`NB_MASTERS-1:0]                         ack_o,
  output periph_bus_pkg::periph_data_t [`NB_MASTERS-1:0] rdata_o,
  output logic                                           bus_req_o,
  output logic                                           bus_we_o,
  output periph_bus_pkg::periph_addr_t                   bus_addr_o,
  output periph_bus_pkg::periph_data_t                   bus_wdata_o,
  input  periph_bus_pkg::periph_data_t                   bus_rdata_i
);
  import periph_bus_pkg::*;

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_ACCESS,
    ARB_ACK_WAIT
  } arb_state_e;

  arb_state_e                     state_q;
  logic [`NB_MASTERS-1:0]         req_q;
  logic [`NB_MASTERS-1:0]         ack_q;
  master_idx_t                    prio_q;
  master_idx_t                    grant_q;
  master_idx_t                    win_idx;
  logic                           win_vld;
  logic                           we_q;
  periph_addr_t                   addr_q;
  periph_data_t                   wdata_q;
  periph_data_t [`NB_MASTERS-1:0] rdata_q;

  // Search from the priority pointer, the pointer itself wins last
  always_comb begin
    win_idx = prio_q;
    win_vld = 1'b0;
    for (int k = `NB_MASTERS-1; k >= 0; k--) begin
      if (req_q[(int'(prio_q) + k) % `NB_MASTERS]) begin
        win_idx = master_idx_t'((int'(prio_q) + k) % `NB_MASTERS);
        win_vld = 1'b1;
      end
    end
  end

  //**************************************************
  // Access FSM
  //**************************************************
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ARB_IDLE;
      req_q   <= '0;
      ack_q   <= '0;
      prio_q  <= '0;
      grant_q <= '0;
    end else begin
      req_q <= req_i;
      case (state_q)
        ARB_IDLE: begin
          if (win_vld) begin
            grant_q <= win_idx;
            prio_q  <= master_idx_t'((int'(win_idx) + 1) % `NB_MASTERS);
            state_q <= ARB_ACCESS;
          end
        end
        ARB_ACCESS: begin
          ack_q[grant_q] <= 1'b1;
          state_q        <= ARB_ACK_WAIT;
        end
        ARB_ACK_WAIT: begin
          // Bus stays blocked until this master releases req
          if (!req_i[grant_q]) begin
            ack_q[grant_q] <= 1'b0;
            state_q        <= ARB_IDLE;
          end
        end
        default: state_q <= ARB_IDLE;
      endcase
    end
  end

  // Request fields latched at grant, read data at the end of the access
  always_ff @(posedge clk_i) begin
    if (state_q == ARB_IDLE && win_vld) begin
      we_q    <= we_i[win_idx];
      addr_q  <= addr_i[win_idx];
      wdata_q <= wdata_i[win_idx];
    end
    if (state_q == ARB_ACCESS) begin
      rdata_q[grant_q] <= bus_rdata_i;
    end
  end

  assign bus_req_o   = (state_q == ARB_ACCESS);
  assign bus_we_o    = we_q;
  assign bus_addr_o  = addr_q;
  assign bus_wdata_o = wdata_q;
  assign ack_o       = ack_q;
  assign rdata_o     = rdata_q;

endmodule

`default_nettype wire

/* source/periph_bus_pkg.sv */
// Types of the shared single-cycle peripheral bus
// Needs cluster_defs.svh for the address width and master count
`default_nettype none

`include "cluster_defs.svh"

package periph_bus_pkg;

  // Full bus address, select field on top of the register offset
  typedef logic [`PERIPH_ADDR_W-1:0] periph_addr_t;

  typedef logic [31:0] periph_data_t;

  // Index of the master that owns the current access
  typedef logic [$clog2(`NB_MASTERS)-1:0] master_idx_t;

  // Decoded target of an access
  typedef enum logic [1:0] {
    CTRL,
    TIMER,
    EU,
    NONE
  } periph_sel_e;

endpackage

`default_nettype wire

/* verif/cluster_periph_stimulus.txt */
# op master addr data expected, numbers in hex, one access or check per line
# out: addr picks 0 fetch_enable 1 boot_addr 2 eoc 3 irq, dual: master 0 writes data, master 1 writes expected
reset 0 000 00000000 1c000000
dual  0 108 00000111 00000222
rd    1 108 00000000 00000222
wr    0 000 00000005 00000000
out   0 000 00000000 00000005
rd    1 000 00000000 00000005
wr    1 004 1c008080 00000000
out   0 001 00000000 1c008080
rd    0 004 00000000 1c008080
wr    0 008 00000001 00000000
out   0 002 00000000 00000001
rd    1 008 00000000 00000001
rd    0 300 00000000 00000000
wr    1 300 ffffffff 00000000
out   0 000 00000000 00000005
out   0 001 00000000 1c008080
wr    0 108 00000014 00000000
wr    1 100 00000001 00000000
poll  0 200 00000001 00000001
wr    0 100 00000000 00000000
wr    1 200 00000001 00000000
rd    0 200 00000000 00000000
wr    0 210 00000008 00000000
wr    1 214 00000001 00000000
wr    0 218 00000008 00000000
rd    1 218 00000000 00000008
out   0 003 00000000 00000000
evt   0 000 00000004 00000000
irq   0 000 00000000 00000005
rd    1 200 00000000 00000008
wr    0 200 00000008 00000000
irq   0 000 00000000 00000000

/* verif/cluster_periph_tb.sv */
// Testbench for cluster_periph_top, driven from verif/cluster_periph_stimulus.txt
// Run from the project root so the stimulus path resolves
// Outputs are sampled on the falling clock edge
`timescale 1ns/100ps
`default_nettype none

`include "cluster_defs.svh"

module cluster_periph_tb;

  localparam int    CLK_PERIOD = 4;
  localparam string STIM_FILE  = "verif/cluster_periph_stimulus.txt";

  logic                                              clk;
  logic                                              reset;
  logic [`NB_MASTERS-1:0]                            req;
  logic [`NB_MASTERS-1:0]                            we;
  logic [`NB_MASTERS-1:0][`PERIPH_ADDR_W-1:0]        addr;
  logic [`NB_MASTERS-1:0][31:0]                      wdata;
  logic [`NB_MASTERS-1:0]                            ack;
  logic [`NB_MASTERS-1:0][31:0]                      rdata;
  logic [6:0]                                        evt;
  logic [`NB_CORES-1:0]                              fetch_enable;
  logic [31:0]                                       boot_addr;
  logic                                              eoc;
  logic [`NB_CORES-1:0]                              irq;

  // Parsed stimulus lines
  string       op_tab[$];
  int          mst_tab[$];
  logic [31:0] addr_tab[$];
  logic [31:0] data_tab[$];
  logic [31:0] exp_tab[$];

  int test_errors;
  int fail_count;
  int check_count;

  cluster_periph_top dut0 (
    .clk_i          (clk),
    .reset_i        (reset),
    .req_i          (req),
    .we_i           (we),
    .addr_i         (addr),
    .wdata_i        (wdata),
    .ack_o          (ack),
    .rdata_o        (rdata),
    .evt_i          (evt),
    .fetch_enable_o (fetch_enable),
    .boot_addr_o    (boot_addr),
    .eoc_o          (eoc),
    .irq_o          (irq)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic load_stimulus(output bit ok);
    int          fd;
    int          cnt;
    string       line;
    string       op;
    int          m;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] e;
    ok = 1'b0;
    fd = $fopen(STIM_FILE, "r");
    if (fd != 0) begin
      ok = 1'b1;
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        cnt = $sscanf(line, "%s %d %h %h %h", op, m, a, d, e);
        // Comment lines stop the scan early
        if (cnt == 5 && op.getc(0) != "#") begin
          op_tab.push_back(op);
          mst_tab.push_back(m);
          addr_tab.push_back(a);
          data_tab.push_back(d);
          exp_tab.push_back(e);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      $display("Mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      test_errors++;
    end
  endtask

  //**************************************************
  // Four-phase handshake on one master port
  //**************************************************
  task automatic bus_access(input int m, input logic wr, input logic [`PERIPH_ADDR_W-1:0] a,
                            input logic [31:0] d, output logic [31:0] rd);
    @(posedge clk);
    req[m]   <= 1'b1;
    we[m]    <= wr;
    addr[m]  <= a;
    wdata[m] <= d;
    do @(negedge clk); while (ack[m] !== 1'b1);
    rd = rdata[m];
    @(posedge clk);
    req[m] <= 1'b0;
    do @(negedge clk); while (ack[m] !== 1'b0);
  endtask

  task automatic run_test(input int i);
    string                    op;
    int                       m;
    logic [`PERIPH_ADDR_W-1:0] a;
    logic [31:0]              d;
    logic [31:0]              e;
    logic [31:0]              got;
    logic [31:0]              got1;
    bit                       found;
    op          = op_tab[i];
    m           = mst_tab[i];
    a           = addr_tab[i][`PERIPH_ADDR_W-1:0];
    d           = data_tab[i];
    e           = exp_tab[i];
    test_errors = 0;
    if (op == "reset") begin
      @(negedge clk);
      check_value("ack_o", 32'(ack), 32'h0);
      check_value("irq_o", 32'(irq), 32'h0);
      check_value("fetch_enable_o", 32'(fetch_enable), 32'h0);
      check_value("eoc_o", 32'(eoc), 32'h0);
      check_value("boot_addr_o", boot_addr, e);
    end else if (op == "wr") begin
      bus_access(m, 1'b1, a, d, got);
    end else if (op == "rd") begin
      bus_access(m, 1'b0, a, 32'h0, got);
      check_value($sformatf("rdata_o[%0d]", m), got, e);
    end else if (op == "dual") begin
      // Both masters request on the same edge
      fork
        bus_access(0, 1'b1, a, d, got);
        bus_access(1, 1'b1, a, e, got1);
      join
    end else if (op == "out") begin
      @(negedge clk);
      case (a[1:0])
        2'd0: check_value("fetch_enable_o", 32'(fetch_enable), e);
        2'd1: check_value("boot_addr_o", boot_addr, e);
        2'd2: check_value("eoc_o", 32'(eoc), e);
        default: check_value("irq_o", 32'(irq), e);
      endcase
    end else if (op == "poll") begin
      found = 1'b0;
      for (int k = 0; k < 40 && !found; k++) begin
        bus_access(m, 1'b0, a, 32'h0, got);
        found = ((got & d) == e);
      end
      check_count++;
      assert (found) else begin
        $display("Polling address %h never returned %h under mask %h", a, e, d);
        test_errors++;
      end
    end else if (op == "evt") begin
      @(posedge clk);
      evt <= d[6:0];
      @(posedge clk);
      evt <= '0;
    end else if (op == "irq") begin
      for (int k = 0; k < 20 && irq !== e[`NB_CORES-1:0]; k++) begin
        @(negedge clk);
      end
      check_value("irq_o", 32'(irq), e);
    end else begin
      $display("Unknown operation %s on stimulus entry %0d", op, i + 1);
      test_errors++;
    end
    if (test_errors != 0) begin
      fail_count++;
    end
    $display("Test %0d (%s): %s", i + 1, op, (test_errors == 0) ? "ok" : "FAILED");
  endtask

  initial begin : main
    bit ok;
    int timeout_ns;
    clk         = 1'b0;
    reset       = 1'b1;
    req         = '0;
    we          = '0;
    addr        = '0;
    wdata       = '0;
    evt         = '0;
    fail_count  = 0;
    check_count = 0;
    load_stimulus(ok);
    if (!ok) begin
      $display("Cannot open the stimulus file %s", STIM_FILE);
      $display("Verification failed");
      $finish;
    end else begin
      timeout_ns = op_tab.size() * 200 * CLK_PERIOD;
      fork
        begin
          #(timeout_ns);
          $display("Timeout, the tests did not finish within %0d ns", timeout_ns);
          $display("Verification failed");
          $finish;
        end
      join_none
      repeat (16) @(posedge clk);
      reset <= 1'b0;
      for (int i = 0; i < op_tab.size(); i++) begin
        run_test(i);
      end
      $display("Tests run %0d, failed %0d, checks %0d", op_tab.size(), fail_count,
               check_count);
      if (fail_count == 0) begin
        $display("Verification passed");
      end else begin
        $display("Verification failed");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire
